/* logic/dmaCfg_defs.svh */
// word width must stay two bytes wide and the status byte assumes exactly four channels
`ifndef DMA_CFG_DEFS_SVH
`define DMA_CFG_DEFS_SVH

// channels served by the register file
`define DMA_CHANNELS 4

// current and base address and count width
`define DMA_WORD_W 16

// host data bus width
`define DMA_BYTE_W 8

// host register address width, 16 register slots
`define DMA_REG_ADDR_W 4

`endif

/* logic/dmaRegPkg.sv */
// host-side formats only; the command and temporary registers of the 8237 are not mapped
`default_nettype none

`include "dmaCfg_defs.svh"

package dmaRegPkg;

  // register map, values follow the host address where one exists
  typedef enum logic [`DMA_REG_ADDR_W-1:0] {
    chanAddr    = 4'h0,
    chanCount   = 4'h1,
    none        = 4'h2,
    status      = 4'h8,
    request     = 4'h9,
    singleMask  = 4'hA,
    mode        = 4'hB,
    clearPtr    = 4'hC,
    masterClear = 4'hD,
    clearMask   = 4'hE,
    allMask     = 4'hF
  } regSelT;

  // transfer type and mode select are decoded but never stored
  typedef struct packed {
    logic [1:0] modeSel;
    logic       decrement;
    logic       autoInit;
    logic [1:0] xferType;
    logic [1:0] chan;
  } modeWordT;

  typedef struct packed {
    logic [4:0] unused;
    logic       setBit;
    logic [1:0] chan;
  } maskWordT;

  typedef struct packed {
    logic [4:0] unused;
    logic       setBit;
    logic [1:0] chan;
  } requestWordT;

  // one written byte, three readings of it
  typedef union packed {
    modeWordT    modeW;
    maskWordT    maskW;
    requestWordT reqW;
  } dataByteU;

endpackage

`default_nettype wire

/* logic/dmaXferPkg.sv */
// transfer-side types; the channel index width follows the channel count
`default_nettype none

`include "dmaCfg_defs.svh"

package dmaXferPkg;

  // channel number
  typedef logic [$clog2(`DMA_CHANNELS)-1:0] chanIdxT;

  // one address or word count
  typedef logic [`DMA_WORD_W-1:0] wordT;

  // only the mode bits that change stepping are kept
  typedef struct packed {
    logic autoInit;
    logic decrement;
  } chanModeT;

endpackage

`default_nettype wire

/* logic/regAccessIf.sv */
// strobes are single-cycle with no handshake; payload is only meaningful while a strobe is high
`timescale 1ns/1ps
`default_nettype none

`include "dmaCfg_defs.svh"

// decoded host access, one per cycle at most
interface regAccessIf
  import dmaRegPkg::*;
  import dmaXferPkg::*;
();
  logic     wrEn;
  logic     rdEn;
  regSelT   regSel;
  chanIdxT  chan;
  // byte pointer as seen by this access
  logic     hiByte;
  dataByteU wrData;
  logic     clearAll;

  modport decoder (output wrEn, rdEn, regSel, chan, hiByte, wrData, clearAll);
  modport bank (input wrEn, regSel, chan, hiByte, wrData, clearAll);
  modport readPort (input rdEn, regSel, chan, hiByte, clearAll);
endinterface

// what the read side may see of the channels
interface chanViewIf
  import dmaXferPkg::*;
();
  wordT                     curAddr [`DMA_CHANNELS];
  wordT                     curCount [`DMA_CHANNELS];
  // one-cycle terminal count pulse per channel
  logic [`DMA_CHANNELS-1:0] tcHit;
  logic [`DMA_CHANNELS-1:0] reqBits;

  modport bank (output curAddr, curCount, tcHit, reqBits);
  modport readPort (input curAddr, curCount, tcHit, reqBits);
endinterface

`default_nettype wire

/* logic/dmaBusDecoder.sv */
// a cycle with both strobes low counts as a write; reads of write-only slots decode to none
`timescale 1ns/1ps
`default_nettype none

`include "dmaCfg_defs.svh"

module dmaBusDecoder
  import dmaRegPkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire logic                       csN,
  input  wire logic                       iorN,
  input  wire logic                       iowN,
  input  wire logic [`DMA_REG_ADDR_W-1:0] addr,
  input  wire logic [`DMA_BYTE_W-1:0]     dataIn,
  regAccessIf.decoder                     acc
);

  logic   hostWr;
  logic   hostRd;
  logic   chanHit;
  logic   bytePtr;
  regSelT selNext;

  assign hostWr = !csN && !iowN;
  assign hostRd = !csN && !iorN && iowN;

  // upper address bit clear means a per-channel address or count slot
  assign chanHit = (hostWr || hostRd) && !addr[`DMA_REG_ADDR_W-1];

  always_comb
  begin
    selNext = none;
    if (!addr[`DMA_REG_ADDR_W-1])
      selNext = addr[0] ? chanCount : chanAddr;
    else if (hostWr)
    begin
      // slot 8 on write is the dropped command register
      case (addr[2:0])
        3'd1:    selNext = request;
        3'd2:    selNext = singleMask;
        3'd3:    selNext = mode;
        3'd4:    selNext = clearPtr;
        3'd5:    selNext = masterClear;
        3'd6:    selNext = clearMask;
        3'd7:    selNext = allMask;
        default: selNext = none;
      endcase
    end
    else if (addr[2:0] == 3'd0)
      selNext = status;
  end

  // strobes and the byte pointer flip-flop
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      acc.wrEn     <= 1'b0;
      acc.rdEn     <= 1'b0;
      acc.clearAll <= 1'b0;
      bytePtr      <= 1'b0;
    end
    else
    begin
      acc.wrEn     <= hostWr;
      acc.rdEn     <= hostRd;
      acc.clearAll <= hostWr && (selNext == masterClear);
      if (hostWr && (selNext == clearPtr || selNext == masterClear))
        bytePtr <= 1'b0;
      else if (chanHit)
        bytePtr <= !bytePtr;
    end
  end

  // access payload, qualified by the strobes above
  always_ff @(posedge clk)
  begin
    acc.regSel <= selNext;
    acc.chan   <= addr[2:1];
    acc.hiByte <= bytePtr;
    acc.wrData <= dataIn;
  end

endmodule

`default_nettype wire

/* logic/dmaChannelBank.sv */
// a host write to the stepping channel's address or count drops that step entirely
`timescale 1ns/1ps
`default_nettype none

`include "dmaCfg_defs.svh"

module dmaChannelBank
  import dmaRegPkg::*;
  import dmaXferPkg::*;
(
  input  wire logic    clk,
  input  wire logic    rstN,
  regAccessIf.bank     acc,
  chanViewIf.bank      view,
  input  wire logic    xferStep,
  input  wire chanIdxT xferChan,
  output wordT         memAddr,
  output logic         tc
);

  localparam wordT wordOne = 1;

  wordT                     baseAddr [`DMA_CHANNELS];
  wordT                     baseCount [`DMA_CHANNELS];
  wordT                     curAddr [`DMA_CHANNELS];
  wordT                     curCount [`DMA_CHANNELS];
  chanModeT                 chanMode [`DMA_CHANNELS];
  logic [`DMA_CHANNELS-1:0] maskBits;
  logic [`DMA_CHANNELS-1:0] reqBits;
  logic [`DMA_CHANNELS-1:0] tcHitQ;
  logic [`DMA_BYTE_W-1:0]   wrByte;
  logic                     hostHit;
  logic                     stepOk;
  logic                     stepLast;

  // replace the byte the pointer selects, keep the other
  function automatic wordT putByte(wordT word, logic hi, logic [`DMA_BYTE_W-1:0] value);
    wordT result;
    result = word;
    if (hi)
      result[`DMA_WORD_W-1:`DMA_BYTE_W] = value;
    else
      result[`DMA_BYTE_W-1:0] = value;
    return result;
  endfunction

  // raw view for the all-mask write
  assign wrByte = acc.wrData;

  assign hostHit = acc.wrEn && (acc.regSel == chanAddr || acc.regSel == chanCount)
                   && (acc.chan == xferChan);
  assign stepOk = xferStep && !maskBits[xferChan] && !hostHit && !acc.clearAll;

  // terminal count when the count is already zero
  assign stepLast = (curCount[xferChan] == '0);

  always_ff @(posedge clk)
  begin
    if (!rstN || acc.clearAll)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
        curAddr[i]   <= '0;
        curCount[i]  <= '0;
        chanMode[i]  <= '0;
      end
      maskBits <= '0;
      reqBits  <= '0;
      tcHitQ   <= '0;
      memAddr  <= '0;
    end
    else
    begin
      tcHitQ <= '0;

      if (stepOk)
      begin
        memAddr <= curAddr[xferChan];
        if (stepLast)
        begin
          tcHitQ[xferChan] <= 1'b1;
          if (chanMode[xferChan].autoInit)
          begin
            curAddr[xferChan]  <= baseAddr[xferChan];
            curCount[xferChan] <= baseCount[xferChan];
          end
          else
          begin
            curAddr[xferChan]  <= '0;
            curCount[xferChan] <= '0;
          end
        end
        else
        begin
          if (chanMode[xferChan].decrement)
            curAddr[xferChan] <= curAddr[xferChan] - wordOne;
          else
            curAddr[xferChan] <= curAddr[xferChan] + wordOne;
          curCount[xferChan] <= curCount[xferChan] - wordOne;
        end
      end

      if (acc.wrEn)
      begin
        case (acc.regSel)
          chanAddr:
          begin
            baseAddr[acc.chan] <= putByte(baseAddr[acc.chan], acc.hiByte, wrByte);
            curAddr[acc.chan]  <= putByte(curAddr[acc.chan], acc.hiByte, wrByte);
          end
          chanCount:
          begin
            baseCount[acc.chan] <= putByte(baseCount[acc.chan], acc.hiByte, wrByte);
            curCount[acc.chan]  <= putByte(curCount[acc.chan], acc.hiByte, wrByte);
          end
          mode:
          begin
            chanMode[acc.wrData.modeW.chan].autoInit  <= acc.wrData.modeW.autoInit;
            chanMode[acc.wrData.modeW.chan].decrement <= acc.wrData.modeW.decrement;
          end
          singleMask:
            maskBits[acc.wrData.maskW.chan] <= acc.wrData.maskW.setBit;
          request:
            reqBits[acc.wrData.reqW.chan] <= acc.wrData.reqW.setBit;
          allMask:
            maskBits <= wrByte[`DMA_CHANNELS-1:0];
          clearMask:
            maskBits <= '0;
          default:
            ;
        endcase
      end
    end
  end

  assign tc           = |tcHitQ;
  assign view.tcHit   = tcHitQ;
  assign view.reqBits = reqBits;
  assign view.curAddr  = curAddr;
  assign view.curCount = curCount;

endmodule

`default_nettype wire

/* logic/dmaReadPort.sv */
// dataOut only changes on a read strobe; the status byte packs four flags over four request bits
`timescale 1ns/1ps
`default_nettype none

`include "dmaCfg_defs.svh"

module dmaReadPort
  import dmaRegPkg::*;
  import dmaXferPkg::*;
(
  input  wire logic               clk,
  input  wire logic               rstN,
  regAccessIf.readPort            acc,
  chanViewIf.readPort             view,
  output logic [`DMA_BYTE_W-1:0]  dataOut
);

  logic [`DMA_CHANNELS-1:0] tcFlags;
  logic [`DMA_BYTE_W-1:0]   statusByte;
  logic [`DMA_BYTE_W-1:0]   rdByte;
  wordT                     chanWord;

  // requests high, terminal counts low
  assign statusByte = {view.reqBits, tcFlags};

  assign chanWord = (acc.regSel == chanCount) ? view.curCount[acc.chan]
                                              : view.curAddr[acc.chan];

  always_comb
  begin
    case (acc.regSel)
      chanAddr, chanCount:
        rdByte = acc.hiByte ? chanWord[`DMA_WORD_W-1:`DMA_BYTE_W]
                            : chanWord[`DMA_BYTE_W-1:0];
      status:
        rdByte = statusByte;
      default:
        rdByte = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN || acc.clearAll)
    begin
      tcFlags <= '0;
      dataOut <= '0;
    end
    else
    begin
      if (acc.rdEn)
        dataOut <= rdByte;
      // a hit arriving with the status read survives the clear
      if (acc.rdEn && acc.regSel == status)
        tcFlags <= view.tcHit;
      else
        tcFlags <= tcFlags | view.tcHit;
    end
  end

endmodule

`default_nettype wire

/* logic/dmaRegFile.sv */
// register file only; no arbitration, no DREQ/DACK and no memory-to-memory transfers
`timescale 1ns/1ps
`default_nettype none

`include "dmaCfg_defs.svh"

module dmaRegFile
  import dmaXferPkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire logic                       csN,
  input  wire logic                       iorN,
  input  wire logic                       iowN,
  input  wire logic [`DMA_REG_ADDR_W-1:0] addr,
  input  wire logic [`DMA_BYTE_W-1:0]     dataIn,
  output logic [`DMA_BYTE_W-1:0]          dataOut,
  input  wire logic                       xferStep,
  input  wire chanIdxT                    xferChan,
  output wordT                            memAddr,
  output logic                            tc
);

  regAccessIf accIf ();
  chanViewIf  viewIf ();

  // host side
  dmaBusDecoder decoder_i (
    .clk    (clk),
    .rstN   (rstN),
    .csN    (csN),
    .iorN   (iorN),
    .iowN   (iowN),
    .addr   (addr),
    .dataIn (dataIn),
    .acc    (accIf.decoder)
  );

  dmaChannelBank bank_i (
    .clk      (clk),
    .rstN     (rstN),
    .acc      (accIf.bank),
    .view     (viewIf.bank),
    .xferStep (xferStep),
    .xferChan (xferChan),
    .memAddr  (memAddr),
    .tc       (tc)
  );

  // read data and status flags
  dmaReadPort readPort_i (
    .clk     (clk),
    .rstN    (rstN),
    .acc     (accIf.readPort),
    .view    (viewIf.readPort),
    .dataOut (dataOut)
  );

endmodule

`default_nettype wire

/* dv/dmaRegFileTb.sv */
// needs --assert and --timing under Verilator; random values come from seed 87, a watchdog ends a stuck run
`timescale 1ns/1ps
`default_nettype none

module dmaRegFileTb;

  logic        clk;
  logic        rstN;
  logic        csN;
  logic        iorN;
  logic        iowN;
  logic [3:0]  addr;
  logic [7:0]  dataIn;
  logic [7:0]  dataOut;
  logic        xferStep;
  logic [1:0]  xferChan;
  logic [15:0] memAddr;
  logic        tc;

  int          errCount;
  int          testErrs;
  int          testsRun;
  int          testsFailed;
  string       curTest;
  logic [31:0] rnd;
  logic [15:0] word;
  logic [15:0] pre;
  logic        tcSeen;
  logic [7:0]  byteRead;
  // current address of each channel as the testbench expects it
  logic [15:0] addrNow [4];

  dmaRegFile dut_i (
    .clk      (clk),
    .rstN     (rstN),
    .csN      (csN),
    .iorN     (iorN),
    .iowN     (iowN),
    .addr     (addr),
    .dataIn   (dataIn),
    .dataOut  (dataOut),
    .xferStep (xferStep),
    .xferChan (xferChan),
    .memAddr  (memAddr),
    .tc       (tc)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = !clk;
  end

  initial
  begin
    #200000;
    $display("watchdog expired before the test sequence finished");
    $display("Checks failed");
    $finish;
  end

  // a terminal count pulse only follows a step
  tcCause: assert property (@(posedge clk) disable iff (!rstN) $rose(tc) |-> $past(xferStep))
  else
  begin
    $display("tc rose at %0t without a step in the cycle before", $time);
    errCount++;
    testErrs++;
  end

  task automatic checkValue(input string what, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Error %s, %s: expected %h, actual %h", curTest, what, expected, actual);
      errCount++;
      testErrs++;
    end
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrs = 0;
  endtask

  task automatic endTest();
    testsRun++;
    if (testErrs > 0)
    begin
      testsFailed++;
      $display("test %s: failed with %0d errors", curTest, testErrs);
    end
    else
      $display("test %s: ok", curTest);
  endtask

  // one host write, strobes low for a single edge
  task automatic hostWrite(input logic [3:0] a, input logic [7:0] d);
    addr = a;
    dataIn = d;
    csN = 1'b0;
    iowN = 1'b0;
    @(posedge clk);
    #1;
    csN = 1'b1;
    iowN = 1'b1;
  endtask

  // data is registered on the second edge after the strobe
  task automatic hostRead(input logic [3:0] a, output logic [7:0] d);
    addr = a;
    csN = 1'b0;
    iorN = 1'b0;
    @(posedge clk);
    #1;
    csN = 1'b1;
    iorN = 1'b1;
    @(posedge clk);
    #1;
    d = dataOut;
  endtask

  task automatic step(input logic [1:0] ch, output logic [15:0] preAddr, output logic tcOut);
    xferStep = 1'b1;
    xferChan = ch;
    @(posedge clk);
    #1;
    xferStep = 1'b0;
    preAddr = memAddr;
    tcOut = tc;
  endtask

  // host register updates land one edge after the access
  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  task automatic writeWord(input logic [1:0] ch, input logic isCount, input logic [15:0] w);
    hostWrite(4'hC, 8'h00);
    hostWrite({1'b0, ch, isCount}, w[7:0]);
    hostWrite({1'b0, ch, isCount}, w[15:8]);
  endtask

  task automatic readWord(input logic [1:0] ch, input logic isCount, output logic [15:0] w);
    logic [7:0] lo;
    logic [7:0] hi;
    hostWrite(4'hC, 8'h00);
    hostRead({1'b0, ch, isCount}, lo);
    hostRead({1'b0, ch, isCount}, hi);
    w = {hi, lo};
  endtask

  task automatic checkChan(input logic [1:0] ch, input logic [15:0] expAddr,
                           input logic [15:0] expCount);
    logic [15:0] got;
    readWord(ch, 1'b0, got);
    checkValue($sformatf("ch%0d address", ch), expAddr, got);
    readWord(ch, 1'b1, got);
    checkValue($sformatf("ch%0d count", ch), expCount, got);
  endtask

  task automatic checkStatus(input logic [7:0] expected);
    logic [7:0] got;
    hostRead(4'h8, got);
    checkValue("status", {8'h00, expected}, {8'h00, got});
  endtask

  // mode select and transfer type are filled with arbitrary values
  function automatic logic [7:0] modeByte(input logic [1:0] ch, input logic autoInit,
                                          input logic decr);
    return {2'b01, decr, autoInit, 2'b10, ch};
  endfunction

  task automatic runToTerminal(input logic [1:0] ch, input logic autoInit, input logic [15:0] k);
    logic [15:0] baseAddr;
    logic [15:0] expAddr;
    logic [15:0] stepNum;
    logic [15:0] stepPre;
    logic        hit;
    rnd = $urandom();
    baseAddr = rnd[15:0];
    hostWrite(4'hB, modeByte(ch, autoInit, 1'b0));
    writeWord(ch, 1'b0, baseAddr);
    writeWord(ch, 1'b1, k);
    checkChan(ch, baseAddr, k);
    expAddr = baseAddr;
    stepNum = 16'd0;
    hit = 1'b0;
    while (!hit && stepNum < k + 16'd4)
    begin
      stepNum = stepNum + 16'd1;
      step(ch, stepPre, hit);
      checkValue("pre-step address", expAddr, stepPre);
      expAddr = expAddr + 16'd1;
    end
    assert (hit)
    else
    begin
      $display("%s: no terminal count on channel %0d after %0d steps", curTest, ch, stepNum);
      errCount++;
      testErrs++;
    end
    if (hit)
      checkValue("terminal step number", k + 16'd1, stepNum);
    // flag reads once, then the status read has cleared it
    checkStatus(8'h01 << ch);
    checkStatus(8'h00);
    if (autoInit)
      checkChan(ch, baseAddr, k);
    else
      checkChan(ch, 16'h0000, 16'h0000);
  endtask

  initial
  begin
    rnd = $urandom(87);
    errCount = 0;
    testErrs = 0;
    testsRun = 0;
    testsFailed = 0;
    csN = 1'b1;
    iorN = 1'b1;
    iowN = 1'b1;
    addr = 4'h0;
    dataIn = 8'h00;
    xferStep = 1'b0;
    xferChan = 2'd0;
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    startTest("reset");
    for (int ch = 0; ch < 4; ch++)
      checkChan(ch[1:0], 16'h0000, 16'h0000);
    checkStatus(8'h00);
    checkValue("tc", 16'h0000, {15'd0, tc});
    endTest();

    startTest("programming");
    for (int ch = 0; ch < 4; ch++)
    begin
      rnd = $urandom();
      writeWord(ch[1:0], 1'b0, rnd[15:0]);
      writeWord(ch[1:0], 1'b1, rnd[31:16]);
      checkChan(ch[1:0], rnd[15:0], rnd[31:16]);
    end
    // stray byte leaves the pointer high, writeWord realigns it with clearPtr
    hostWrite(4'h1, 8'hEE);
    rnd = $urandom();
    writeWord(2'd0, 1'b1, rnd[15:0]);
    // a single read flips the pointer parity ahead of the word readback
    hostRead(4'h1, byteRead);
    checkValue("count low byte after realign", {8'h00, rnd[7:0]}, {8'h00, byteRead});
    readWord(2'd0, 1'b1, word);
    checkValue("count after realign", rnd[15:0], word);
    endTest();

    startTest("stepping");
    // channel 1 counts up, channel 2 counts down
    for (int ch = 1; ch < 3; ch++)
    begin
      rnd = $urandom();
      word = rnd[15:0];
      hostWrite(4'hB, modeByte(ch[1:0], 1'b0, ch == 2));
      writeWord(ch[1:0], 1'b0, word);
      writeWord(ch[1:0], 1'b1, 16'd20);
      checkChan(ch[1:0], word, 16'd20);
      for (int n = 0; n < 5; n++)
      begin
        step(ch[1:0], pre, tcSeen);
        checkValue("pre-step address", word, pre);
        checkValue("tc", 16'h0000, {15'd0, tcSeen});
        word = (ch == 2) ? word - 16'd1 : word + 16'd1;
      end
      checkChan(ch[1:0], word, 16'd15);
      addrNow[ch] = word;
    end
    endTest();

    startTest("terminal count");
    runToTerminal(2'd3, 1'b1, 16'd3);
    runToTerminal(2'd0, 1'b0, 16'd2);
    endTest();

    startTest("mask and request");
    hostWrite(4'hA, 8'h05);
    idle(1);
    step(2'd1, pre, tcSeen);
    step(2'd1, pre, tcSeen);
    checkChan(2'd1, addrNow[1], 16'd15);
    hostWrite(4'hE, 8'h00);
    idle(1);
    step(2'd1, pre, tcSeen);
    checkChan(2'd1, addrNow[1] + 16'd1, 16'd14);
    hostWrite(4'hF, 8'h0F);
    idle(1);
    step(2'd2, pre, tcSeen);
    checkChan(2'd2, addrNow[2], 16'd15);
    hostWrite(4'hE, 8'h00);
    idle(1);
    step(2'd2, pre, tcSeen);
    checkChan(2'd2, addrNow[2] - 16'd1, 16'd14);
    // set requests on channels 2 and 0, then drop channel 2
    hostWrite(4'h9, 8'h06);
    hostWrite(4'h9, 8'h04);
    checkStatus(8'h50);
    hostWrite(4'h9, 8'h02);
    checkStatus(8'h10);
    endTest();

    startTest("master clear");
    // single byte leaves the pointer high before the clear
    hostWrite(4'h2, 8'h77);
    hostWrite(4'hD, 8'h00);
    hostWrite(4'h0, 8'hA5);
    hostWrite(4'h0, 8'h3C);
    checkValue("memAddr", 16'h0000, memAddr);
    checkValue("tc", 16'h0000, {15'd0, tc});
    checkChan(2'd0, 16'h3CA5, 16'h0000);
    for (int ch = 1; ch < 4; ch++)
      checkChan(ch[1:0], 16'h0000, 16'h0000);
    checkStatus(8'h00);
    endTest();

    $display("summary: %0d tests run, %0d tests failing, %0d errors",
             testsRun, testsFailed, errCount);
    if (errCount == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
logic/dmaRegPkg.sv
logic/dmaXferPkg.sv
logic/regAccessIf.sv
logic/dmaBusDecoder.sv
logic/dmaChannelBank.sv
logic/dmaReadPort.sv
logic/dmaRegFile.sv
dv/dmaRegFileTb.sv

/* Makefile */
# Verilator build and run of the DMA register file testbench

SIM       ?= verilator
TOP       ?= dmaRegFileTb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' sources.f)
HEADERS := $(wildcard logic/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) sources.f
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
